/* source/lsu_params.svh */
// sizing macros for the load/store unit
// the data path slicing assumes a 32-bit bus with four byte lanes
// LSU_DEPTH must be a power of two, the queue pointers wrap freely

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

//////////////////////////////
// bus geometry
`define LSU_DATA_W 32           // data bus width in bits
`define LSU_ADDR_W 32           // byte address width
`define LSU_OFS_W  2            // byte offset inside one word

//////////////////////////////
// outstanding transactions
`define LSU_DEPTH  2            // max granted but unanswered requests

`endif

/* source/lsu_pkg.sv */
// shared types of the load/store unit, used by RTL and testbench
// byte-enable width follows LSU_DATA_W / 8

`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  // access size, encoding kept from the core's data type field
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_size_e;

  typedef enum logic {
    LSU_EXT_ZERO = 1'b0,
    LSU_EXT_SIGN = 1'b1
  } lsu_ext_e;

  // phase of a possibly split access
  typedef enum logic {
    LSU_PH_FIRST  = 1'b0,         // single access or first half of a split one
    LSU_PH_SECOND = 1'b1          // next word of a split access
  } lsu_phase_e;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] op_a;       // base address operand
    logic [`LSU_ADDR_W-1:0] op_b;       // offset operand
    logic                   use_incr;   // address = a + b when set, else a
    logic                   we;         // store when set
    lsu_size_e              size;
    lsu_ext_e               ext;        // loads only
    logic [`LSU_DATA_W-1:0] wdata;      // store data, lsb aligned
  } lsu_op_t;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0]   addr;
    logic                     we;
    logic [`LSU_DATA_W/8-1:0] be;
    logic [`LSU_DATA_W-1:0]   wdata;    // already rotated onto the lanes
  } lsu_bus_req_t;

  // per-transaction info needed when the response comes back
  typedef struct packed {
    lsu_size_e            size;
    lsu_ext_e             ext;
    logic [`LSU_OFS_W-1:0] ofs;        // byte offset of the original address
    logic                 first_half; // first response of a split load
    logic                 we;         // write responses carry no result
  } lsu_rd_desc_t;

endpackage

`default_nettype wire

/* source/lsu_ctrl.sv */
// phase FSM and request/grant handling for one operation at a time
// the bus request is combinational from op_valid_i, the operand side must
// hold op_i stable until op_ready_o, which keeps bus_o stable until grant
// a split access is sequenced here, the core issues it only once

`default_nettype none

module lsu_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                op_valid_i,    // operation waiting in execute
  input  logic                misaligned_i,  // current op needs two transactions
  input  logic                queue_full_i,  // LSU_DEPTH transactions in flight
  input  logic                bus_gnt_i,
  output logic                bus_req_o,
  output logic                op_ready_o,    // op consumed this cycle
  output logic                push_o,        // queue a descriptor
  output lsu_pkg::lsu_phase_e phase_o
);

  import lsu_pkg::*;

  lsu_phase_e phase_q;
  lsu_phase_e phase_d;
  logic       grant;       // request accepted by the bus
  logic       last_phase;  // this grant finishes the operation

  //////////////////////////////
  // request side

  // no room in the queue means no request, the count only drops until
  // the next grant so a raised request is never withdrawn
  assign bus_req_o  = op_valid_i & ~queue_full_i;
  assign grant      = bus_req_o & bus_gnt_i;

  // aligned ops finish on their only grant, split ops on the second one
  assign last_phase = (phase_q == LSU_PH_SECOND) | ~misaligned_i;

  assign push_o     = grant;               // one descriptor per transaction
  assign op_ready_o = grant & last_phase;

  //////////////////////////////
  // phase FSM

  always_comb begin
    phase_d = phase_q;
    unique case (phase_q)
      LSU_PH_FIRST: begin
        if (grant && misaligned_i) begin
          phase_d = LSU_PH_SECOND;         // upper word follows next cycle
        end
      end
      LSU_PH_SECOND: begin
        if (grant) begin
          phase_d = LSU_PH_FIRST;          // split op done
        end
      end
      default: phase_d = LSU_PH_FIRST;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= LSU_PH_FIRST;
    end else begin
      phase_q <= phase_d;
    end
  end

  assign phase_o = phase_q;

endmodule

`default_nettype wire

/* source/lsu_req_gen.sv */
// address, byte enables and store lane rotation for the current phase
// purely combinational, follows op_i and phase_i directly
// misaligned words and halfwords at offset 3 go out as two word accesses

`default_nettype none

`include "lsu_params.svh"

module lsu_req_gen (
  input  lsu_pkg::lsu_op_t      op_i,
  input  lsu_pkg::lsu_phase_e   phase_i,
  output logic                  misaligned_o,  // access crosses a word boundary
  output lsu_pkg::lsu_bus_req_t bus_o,
  output lsu_pkg::lsu_rd_desc_t desc_o        // info for the response path
);

  import lsu_pkg::*;

  logic [`LSU_ADDR_W-1:0]   addr;     // effective byte address
  logic [`LSU_OFS_W-1:0]    ofs;
  logic [`LSU_DATA_W/8-1:0] be;
  logic [`LSU_DATA_W-1:0]   wdata_rot;
  logic                     second;

  assign addr   = op_i.use_incr ? (op_i.op_a + op_i.op_b) : op_i.op_a;
  assign ofs    = addr[`LSU_OFS_W-1:0];
  assign second = (phase_i == LSU_PH_SECOND);

  assign misaligned_o = ((op_i.size == LSU_WORD) && (ofs != '0)) ||
                        ((op_i.size == LSU_HALF) && (ofs == 2'b11));

  //////////////////////////////
  // byte enables

  always_comb begin
    unique case (op_i.size)
      LSU_WORD: begin
        case (ofs)
          2'b00:   be = second ? 4'b0000 : 4'b1111; // second phase never seen here
          2'b01:   be = second ? 4'b0001 : 4'b1110;
          2'b10:   be = second ? 4'b0011 : 4'b1100;
          default: be = second ? 4'b0111 : 4'b1000;
        endcase
      end
      LSU_HALF: begin
        case (ofs)
          2'b00:   be = 4'b0011;
          2'b01:   be = 4'b0110;
          2'b10:   be = 4'b1100;
          default: be = second ? 4'b0001 : 4'b1000; // split at offset 3
        endcase
      end
      default: be = 4'b0001 << ofs;        // bytes never split
    endcase
  end

  // rotate left by the byte offset, the wrapped bytes feed the second phase
  always_comb begin
    case (ofs)
      2'b00:   wdata_rot = op_i.wdata;
      2'b01:   wdata_rot = {op_i.wdata[23:0], op_i.wdata[31:24]};
      2'b10:   wdata_rot = {op_i.wdata[15:0], op_i.wdata[31:16]};
      default: wdata_rot = {op_i.wdata[7:0],  op_i.wdata[31:8]};
    endcase
  end

  //////////////////////////////
  // outputs

  // second phase targets the next word, low lanes
  assign bus_o.addr  = second ? {addr[`LSU_ADDR_W-1:`LSU_OFS_W] + 1'b1, {`LSU_OFS_W{1'b0}}}
                              : addr;
  assign bus_o.we    = op_i.we;
  assign bus_o.be    = be;
  assign bus_o.wdata = wdata_rot;

  assign desc_o.size       = op_i.size;
  assign desc_o.ext        = op_i.ext;
  assign desc_o.ofs        = ofs;                  // original offset in both phases
  assign desc_o.first_half = misaligned_o & ~second;
  assign desc_o.we         = op_i.we;

endmodule

`default_nettype wire

/* source/lsu_resp_queue.sv */
// in-order descriptor FIFO, one entry per granted transaction
// responses must arrive in grant order, a pop on an empty queue is ignored
// the head entry is valid only while the count is nonzero

`default_nettype none

`include "lsu_params.svh"

module lsu_resp_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_i,   // bus grant
  input  lsu_pkg::lsu_rd_desc_t desc_i,
  input  logic                  pop_i,    // bus response
  output lsu_pkg::lsu_rd_desc_t head_o,   // descriptor of the oldest transaction
  output logic                  full_o
);

  import lsu_pkg::*;

  localparam int PTR_W = $clog2(`LSU_DEPTH);
  localparam int CNT_W = $clog2(`LSU_DEPTH + 1);

  lsu_rd_desc_t     mem_q [`LSU_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;    // outstanding transactions
  logic             do_push;
  logic             do_pop;

  assign full_o  = (cnt_q == CNT_W'(`LSU_DEPTH));
  assign do_push = push_i & ~full_o;         // ctrl never pushes when full
  assign do_pop  = pop_i & (cnt_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;            // push and pop together keep it
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= desc_i;
    end
  end

  assign head_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

/* source/lsu_rdata_align.sv */
// load data alignment and extension on the response path
// head_i must describe the response on rdata_i in the cycle of rvalid_i
// a split load keeps its first word here until the second one arrives

`default_nettype none

`include "lsu_params.svh"

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rvalid_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  input  lsu_pkg::lsu_rd_desc_t  head_i,
  output logic                   res_valid_o,  // one pulse per load
  output logic [`LSU_DATA_W-1:0] res_data_o
);

  import lsu_pkg::*;

  logic [`LSU_DATA_W-1:0] rdata_q;   // first word of a split load
  logic [`LSU_DATA_W-1:0] word_asm;
  logic [15:0]            half_sel;
  logic [7:0]             byte_sel;
  logic                   sext;

  // keep the lower word, its upper lanes hold the low bytes of the value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rvalid_i && !head_i.we && head_i.first_half) begin
      rdata_q <= rdata_i;
    end
  end

  //////////////////////////////
  // lane selection

  // misaligned words come from buffered upper bytes and new low bytes
  always_comb begin
    case (head_i.ofs)
      2'b00:   word_asm = rdata_i;
      2'b01:   word_asm = {rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   word_asm = {rdata_i[15:0], rdata_q[31:16]};
      default: word_asm = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (head_i.ofs)
      2'b00:   half_sel = rdata_i[15:0];
      2'b01:   half_sel = rdata_i[23:8];
      2'b10:   half_sel = rdata_i[31:16];
      default: half_sel = {rdata_i[7:0], rdata_q[31:24]}; // crosses the word
    endcase
  end

  assign byte_sel = rdata_i[8*head_i.ofs +: 8];

  //////////////////////////////
  // extension

  assign sext = (head_i.ext == LSU_EXT_SIGN);

  always_comb begin
    unique case (head_i.size)
      LSU_WORD: res_data_o = word_asm;
      LSU_HALF: res_data_o = {{16{sext & half_sel[15]}}, half_sel};
      default:  res_data_o = {{24{sext & byte_sel[7]}}, byte_sel};
    endcase
  end

  // stores and first halves give no result
  assign res_valid_o = rvalid_i & ~head_i.we & ~head_i.first_half;

endmodule

`default_nettype wire

/* source/lsu_top.sv */
// load/store unit top, one operation at a time, up to LSU_DEPTH in flight
// op_i is held until op_ready_o, bus_o is held until bus_gnt_i
// bus responses come in order, at least one cycle after their grant
// res_valid_o has no back-pressure, the consumer must take every pulse

`default_nettype none

`include "lsu_params.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // execute stage side
  input  logic                   op_valid_i,
  input  lsu_pkg::lsu_op_t       op_i,
  output logic                   op_ready_o,
  output logic                   res_valid_o,
  output logic [`LSU_DATA_W-1:0] res_data_o,
  // data bus
  output logic                   bus_req_o,
  output lsu_pkg::lsu_bus_req_t  bus_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] bus_rdata_i
);

  import lsu_pkg::*;

  logic         misaligned;
  logic         queue_full;
  logic         push;        // grant, descriptor enters the queue
  lsu_phase_e   phase;
  lsu_rd_desc_t desc;        // descriptor of the current request
  lsu_rd_desc_t head;        // descriptor of the oldest outstanding one

  lsu_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid_i   (op_valid_i),
    .misaligned_i (misaligned),
    .queue_full_i (queue_full),
    .bus_gnt_i    (bus_gnt_i),
    .bus_req_o    (bus_req_o),
    .op_ready_o   (op_ready_o),
    .push_o       (push),
    .phase_o      (phase)
  );

  lsu_req_gen u_req_gen (
    .op_i         (op_i),
    .phase_i      (phase),
    .misaligned_o (misaligned),
    .bus_o        (bus_o),
    .desc_o       (desc)
  );

  lsu_resp_queue u_resp_queue (
    .clk    (clk),
    .rst_n  (rst_n),
    .push_i (push),
    .desc_i (desc),
    .pop_i  (bus_rvalid_i),   // every response retires one entry
    .head_o (head),
    .full_o (queue_full)
  );

  lsu_rdata_align u_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .rvalid_i    (bus_rvalid_i),
    .rdata_i     (bus_rdata_i),
    .head_i      (head),
    .res_valid_o (res_valid_o),
    .res_data_o  (res_data_o)
  );

endmodule

`default_nettype wire

/* sim/lsu_chk.sv */
// concurrent checks on the bus handshake and the outstanding count
// bound into lsu_top, connects to its ports only

`default_nettype none

`include "lsu_params.svh"

module lsu_chk (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  bus_req_i,
  input  logic                  bus_gnt_i,
  input  logic                  bus_rvalid_i,
  input  logic                  op_ready_i,
  input  lsu_pkg::lsu_bus_req_t bus_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int n_out;  // granted but unanswered

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      n_out <= 0;
    end else begin
      n_out <= n_out + int'(bus_req_i && bus_gnt_i) - int'(bus_rvalid_i);
    end
  end

  //////////////////////////////
  // bus protocol

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i && !bus_gnt_i |=> bus_req_i)
    else $error("bus request dropped before its grant");

  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i && !bus_gnt_i |=> $stable(bus_i))
    else $error("bus request changed while waiting for grant");

  // a grant that does not finish the op is the first half of a split access
  split_next: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i && bus_gnt_i && !op_ready_i |=> bus_req_i || n_out == `LSU_DEPTH)
    else $error("second request of a split access not raised");

  depth_limit: assert property (@(posedge clk) disable iff (!rst_n)
    n_out <= `LSU_DEPTH && (bus_rvalid_i -> n_out > 0))
    else $error("outstanding count out of range");

endmodule

`default_nettype wire

/* sim/lsu_tb_checker.sv */
// predicts bus requests and load results from the ops and a shadow memory
// samples on the rising edge, the testbench drives on the falling edge
// loads may only read bytes that an earlier store in the run wrote

`default_nettype none

module lsu_tb_checker #(
  parameter int N_TESTS = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  op_valid_i,
  input  lsu_pkg::lsu_op_t      op_i,
  input  logic                  op_ready_i,
  input  logic                  res_valid_i,
  input  logic [31:0]           res_data_i,
  input  logic                  bus_req_i,
  input  lsu_pkg::lsu_bus_req_t bus_i,
  input  logic                  bus_gnt_i,
  input  logic                  bus_rvalid_i,
  input  int                    row_idx_i,   // table row being issued
  input  logic [127:0]          name_i,
  input  logic [31:0]           exp_i,       // table's expected load data
  output int                    n_errors_o,
  output int                    n_pass_o,
  output int                    n_done_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  logic [7:0]   shadow [logic [31:0]];
  logic [127:0] names [N_TESTS];
  logic [31:0]  exps [N_TESTS];
  int           errs [N_TESTS];
  int           q_idx [$];            // loads waiting for a result
  logic [31:0]  q_pred [$];
  int           n_gnt;                // grants of the current op
  int           n_out;                // outstanding transactions
  int           peak_out;             // most transactions seen in flight

  task automatic log_error(input int idx, input string msg);
    $display("%0s", msg);
    errs[idx]++;
    n_errors_o++;
  endtask

  task automatic bad_value(input int idx, input string sig, input logic [31:0] e,
                           input logic [31:0] g);
    log_error(idx, $sformatf("mismatch %0s exp %h got %h", sig, e, g));
  endtask

  task automatic end_row(input int idx);
    if (n_done_o == N_TESTS - 1 && peak_out < 2) begin
      log_error(idx, "never had two bus transactions in flight");
    end
    if (errs[idx] == 0) begin
      $display("%0s: ok", names[idx]);
      n_pass_o++;
    end else begin
      $display("%0s: FAILED with %0d errors", names[idx], errs[idx]);
    end
    n_done_o++;
    if (n_done_o == N_TESTS) begin
      $display("%0d tests, %0d passed, %0d failed, %0d errors", N_TESTS, n_pass_o,
               N_TESTS - n_pass_o, n_errors_o);
    end
  endtask

  always @(posedge clk) begin : compare
    logic [31:0] a;
    logic [31:0] pred;
    logic [7:0]  mask;   // byte lanes over this word and the next
    int          ofs;
    int          n;
    int          idx;
    int          lane;
    if (rst_n) begin
      a    = op_i.use_incr ? op_i.op_a + op_i.op_b : op_i.op_a;
      ofs  = int'(a[1:0]);
      n    = (op_i.size == LSU_WORD) ? 4 : (op_i.size == LSU_HALF) ? 2 : 1;
      mask = 8'(((1 << n) - 1) << ofs);
      if (op_valid_i) begin
        names[row_idx_i] = name_i;
        exps[row_idx_i]  = exp_i;
      end
      if (res_valid_i) begin
        if (q_idx.size() == 0) begin
          log_error(row_idx_i, "load result arrived with no load pending");
        end else begin
          idx  = q_idx.pop_front();
          pred = q_pred.pop_front();
          if (res_data_i !== pred) bad_value(idx, "res_data_o", pred, res_data_i);
          if (res_data_i !== exps[idx]) bad_value(idx, "res_data_o", exps[idx], res_data_i);
          end_row(idx);
        end
      end
      if (bus_req_i && n_out >= 2) begin
        log_error(row_idx_i, "bus request raised with two outstanding");
      end
      if (bus_req_i && bus_gnt_i) begin
        if (n_gnt == 0) begin
          if (bus_i.addr !== a) bad_value(row_idx_i, "bus_o.addr", a, bus_i.addr);
          if (bus_i.be !== mask[3:0]) begin
            bad_value(row_idx_i, "bus_o.be", 32'(mask[3:0]), 32'(bus_i.be));
          end
        end else begin
          if (bus_i.addr !== {a[31:2] + 30'd1, 2'b00}) begin
            bad_value(row_idx_i, "bus_o.addr", {a[31:2] + 30'd1, 2'b00}, bus_i.addr);
          end
          if (bus_i.be !== mask[7:4]) begin
            bad_value(row_idx_i, "bus_o.be", 32'(mask[7:4]), 32'(bus_i.be));
          end
        end
        if (bus_i.we !== op_i.we) bad_value(row_idx_i, "bus_o.we", 32'(op_i.we), 32'(bus_i.we));
        if (op_i.we) begin
          // byte i of the store lands on lane (ofs + i) of the first or the next word
          for (int i = 0; i < n; i++) begin
            lane = (ofs + i) % 4;
            if (((ofs + i < 4) == (n_gnt == 0)) &&
                (bus_i.wdata[8*lane +: 8] !== op_i.wdata[8*i +: 8])) begin
              bad_value(row_idx_i, "bus_o.wdata", 32'(op_i.wdata[8*i +: 8]),
                        32'(bus_i.wdata[8*lane +: 8]));
            end
          end
        end
        n_gnt++;
      end
      n_out = n_out + ((bus_req_i && bus_gnt_i) ? 1 : 0) - (bus_rvalid_i ? 1 : 0);
      if (n_out > peak_out) peak_out = n_out;
      if (op_valid_i && op_ready_i) begin
        if (n_gnt != ((mask[7:4] != 0) ? 2 : 1)) begin
          log_error(row_idx_i, $sformatf("operation took %0d bus transactions", n_gnt));
        end
        if (op_i.we) begin
          for (int i = 0; i < n; i++) shadow[a + i] = op_i.wdata[8*i +: 8];
          end_row(row_idx_i);
        end else begin
          pred = '0;
          for (int i = 0; i < n; i++) begin
            if (!shadow.exists(a + i)) log_error(row_idx_i, "load reads a byte never stored");
            else pred[8*i +: 8] = shadow[a + i];
          end
          if (op_i.ext == LSU_EXT_SIGN) begin
            for (int j = 8 * n; j < 32; j++) pred[j] = pred[8*n-1];  // copy the top bit
          end
          q_idx.push_back(row_idx_i);
          q_pred.push_back(pred);
        end
        n_gnt = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/lsu_tb.sv */
// testbench top with clock, reset, op table and a randomized bus memory
// grants come 0 to 2 cycles after a request, responses 1 to 3 cycles later,
// or 5 cycles later while a slow row is being issued

`default_nettype none

module lsu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  typedef struct packed {
    logic [127:0] name;
    lsu_op_t      op;
    logic [31:0]  exp;    // expected load data
    logic         slow;   // long response latency
  } row_t;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         op_valid;
  lsu_op_t      op;
  logic         op_ready;
  logic         res_valid;
  logic [31:0]  res_data;
  logic         bus_req;
  lsu_bus_req_t bus;
  logic         bus_gnt;
  logic         bus_rvalid;
  logic [31:0]  bus_rdata;
  row_t         rows [$];
  row_t         cur;
  int           row_idx;
  int           cyc;
  int           gnt_wait;
  int           n_errors;
  int           n_pass;
  int           n_done;
  logic [7:0]   mem [logic [31:0]];
  logic [31:0]  rsp_data [$];
  int           rsp_due [$];     // cycle count at which to answer

  always #4 clk = ~clk;

  lsu_top u_lsu_top (
    .clk(clk), .rst_n(rst_n), .op_valid_i(op_valid), .op_i(op), .op_ready_o(op_ready),
    .res_valid_o(res_valid), .res_data_o(res_data), .bus_req_o(bus_req), .bus_o(bus),
    .bus_gnt_i(bus_gnt), .bus_rvalid_i(bus_rvalid), .bus_rdata_i(bus_rdata)
  );

  bind lsu_top lsu_chk u_chk (
    .clk(clk), .rst_n(rst_n), .bus_req_i(bus_req_o), .bus_gnt_i(bus_gnt_i),
    .bus_rvalid_i(bus_rvalid_i), .op_ready_i(op_ready_o), .bus_i(bus_o)
  );

  lsu_tb_checker #(.N_TESTS(15)) u_checker (
    .clk(clk), .rst_n(rst_n), .op_valid_i(op_valid), .op_i(op), .op_ready_i(op_ready),
    .res_valid_i(res_valid), .res_data_i(res_data), .bus_req_i(bus_req), .bus_i(bus),
    .bus_gnt_i(bus_gnt), .bus_rvalid_i(bus_rvalid), .row_idx_i(row_idx), .name_i(cur.name),
    .exp_i(cur.exp), .n_errors_o(n_errors), .n_pass_o(n_pass), .n_done_o(n_done)
  );

  task automatic add_row(input logic [127:0] name, input logic we, input lsu_size_e size,
                         input lsu_ext_e ext, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] wdata, input logic [31:0] exp, input logic slow);
    row_t r;
    r.op       = '{op_a: a, op_b: b, use_incr: (b != 0), we: we, size: size, ext: ext,
                   wdata: wdata};
    r.name     = name;
    r.exp      = exp;
    r.slow     = slow;
    rows.push_back(r);
  endtask

  // unwritten bytes read back a pattern of the whole address
  function automatic logic [7:0] mem_rd(input logic [31:0] addr);
    if (mem.exists(addr)) return mem[addr];
    return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'ha5;
  endfunction

  //////////////////////////////
  // bus memory model
  always @(posedge clk) begin : bus_model
    logic [31:0] rd;
    int          due;
    if (rst_n && bus_req && bus_gnt) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.we && bus.be[i]) mem[{bus.addr[31:2], 2'b00} + i] = bus.wdata[8*i +: 8];
        rd[8*i +: 8] = mem_rd({bus.addr[31:2], 2'b00} + i);
      end
      due = cyc + (cur.slow ? 5 : int'($urandom_range(3, 1)));
      if (rsp_due.size() > 0 && due <= rsp_due[$]) due = rsp_due[$] + 1;  // in order
      rsp_due.push_back(due);
      rsp_data.push_back(rd);
      gnt_wait = int'($urandom_range(2, 0));
    end else if (rst_n && bus_req && gnt_wait > 0) begin
      gnt_wait--;
    end
    cyc++;
  end

  always @(negedge clk) begin : bus_drive
    bus_gnt    <= (gnt_wait == 0);
    bus_rvalid <= 1'b0;
    if (rsp_due.size() > 0 && rsp_due[0] == cyc) begin
      bus_rvalid <= 1'b1;
      bus_rdata  <= rsp_data.pop_front();
      void'(rsp_due.pop_front());
    end
  end

  always @(negedge clk) begin : watchdog
    if (cyc > 4 + 20 * rows.size()) begin
      $display("run stopped by timeout after %0d cycles", cyc);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin : stimulus
    void'($urandom(32'h53b4_060b));
    rst_n      = 1'b0;
    op_valid   = 1'b0;
    op         = '0;
    cur        = '0;
    row_idx    = 0;
    bus_gnt    = 1'b0;
    bus_rvalid = 1'b0;
    bus_rdata  = '0;
    cyc        = 0;
    gnt_wait   = 0;
    add_row("st_word",      1, LSU_WORD, LSU_EXT_ZERO, 32'h100, 0, 32'h8bad_f00d, 0, 0);
    add_row("ld_word",      0, LSU_WORD, LSU_EXT_ZERO, 32'h100, 0, 0, 32'h8bad_f00d, 0);
    add_row("st_half",      1, LSU_HALF, LSU_EXT_ZERO, 32'h104, 2, 32'h0000_c3a5, 0, 0);
    add_row("ld_half_sext", 0, LSU_HALF, LSU_EXT_SIGN, 32'h106, 0, 0, 32'hffff_c3a5, 0);
    add_row("ld_half_zext", 0, LSU_HALF, LSU_EXT_ZERO, 32'h104, 2, 0, 32'h0000_c3a5, 0);
    add_row("st_byte",      1, LSU_BYTE, LSU_EXT_ZERO, 32'h10b, 0, 32'h0000_009e, 0, 0);
    add_row("ld_byte_sext", 0, LSU_BYTE, LSU_EXT_SIGN, 32'h10b, 0, 0, 32'hffff_ff9e, 0);
    add_row("ld_byte_zext", 0, LSU_BYTE, LSU_EXT_ZERO, 32'h10b, 0, 0, 32'h0000_009e, 0);
    add_row("st_word_mis",  1, LSU_WORD, LSU_EXT_ZERO, 32'h201, 0, 32'h1234_5678, 0, 0);
    add_row("ld_word_mis",  0, LSU_WORD, LSU_EXT_ZERO, 32'h1ff, 2, 0, 32'h1234_5678, 0);
    add_row("st_half_mis",  1, LSU_HALF, LSU_EXT_ZERO, 32'h213, 0, 32'h0000_8001, 0, 0);
    add_row("ld_half_mis",  0, LSU_HALF, LSU_EXT_SIGN, 32'h213, 0, 0, 32'hffff_8001, 0);
    add_row("ld_slow_a",    0, LSU_WORD, LSU_EXT_ZERO, 32'h100, 0, 0, 32'h8bad_f00d, 1);
    add_row("ld_slow_b",    0, LSU_HALF, LSU_EXT_ZERO, 32'h106, 0, 0, 32'h0000_c3a5, 1);
    add_row("ld_slow_c",    0, LSU_BYTE, LSU_EXT_ZERO, 32'h10b, 0, 0, 32'h0000_009e, 1);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      cur      = rows[i];
      row_idx  = i;
      op       = rows[i].op;
      op_valid = 1'b1;
      do @(posedge clk); while (!op_ready);   // wait for acceptance
      @(negedge clk);
    end
    op_valid = 1'b0;
    while (n_done < rows.size()) @(posedge clk);
    @(negedge clk);
    if (n_errors == 0 && n_pass == rows.size()) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/lsu_pkg.sv
source/lsu_ctrl.sv
source/lsu_req_gen.sv
source/lsu_resp_queue.sv
source/lsu_rdata_align.sv
source/lsu_top.sv
sim/lsu_chk.sv
sim/lsu_tb_checker.sv
sim/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, a nonzero exit status means failure
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module lsu_tb -o lsu_sim \
  && ./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
